// ==== sim.f ====
mem_pkg.sv
gfx_slot_if.sv
rom_header_regs.sv
rom_loader.sv
gfx_bank_map.sv
rom_slot_arbiter.sv
mem_map_top.sv
sdram_model.sv
tb_mem_map.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory map testbench with verilator
rm -f sim.log &&
    verilator --binary --timing --top-module tb_mem_map -f sim.f -o tb_mem_map &&
    ./obj_dir/tb_mem_map | tee sim.log &&
    grep -q "SIMULATION PASSED" sim.log || exit 1

// ==== tb_mem_map.sv ====
// memory map testbench
`timescale 1ns/1ns

module tb_mem_map;
    localparam int CLK_PERIOD = 100;
    localparam int N_TARGETS  = 12;
    localparam int DL_BYTES   = 32 + 16 + N_TARGETS * 8 + 1;
    localparam int N_FETCHES  = 2 * N_TARGETS + 4;
    localparam logic [24:0] GFX_BASE = 25'(mem_pkg::HEADER_LEN) + mem_pkg::GFX_START;

    logic                         clk;
    logic                         rst;
    logic                         downloading;
    logic [24:0]                  ioctl_addr;
    logic [7:0]                   ioctl_dout;
    logic                         ioctl_wr;
    logic                         dwnld_busy;
    logic [7:0]                   game_id;
    logic                         dec_en;
    logic [mem_pkg::SDRAM_AW-1:0] prog_addr;
    logic [mem_pkg::SDRAM_DW-1:0] prog_data;
    logic [1:0]                   prog_ba;
    logic                         prog_we;
    logic                         prog_ack;
    logic                         lvbl;
    logic [8:0]                   vrender;
    logic [5:0]                   tile_bank;
    logic [mem_pkg::SLOT_AW-1:0]  scr1_addr;
    logic                         scr1_cs;
    logic                         scr1_ok;
    logic [mem_pkg::SLOT_DW-1:0]  scr1_data;
    logic [mem_pkg::SLOT_AW-1:0]  scr2_addr;
    logic                         scr2_cs;
    logic                         scr2_ok;
    logic [mem_pkg::SLOT_DW-1:0]  scr2_data;
    logic [mem_pkg::SDRAM_AW-1:0] sdram_addr;
    logic                         sdram_req;
    logic                         sdram_ack;
    logic                         sdram_dst;
    logic                         sdram_rdy;
    logic [mem_pkg::SDRAM_DW-1:0] sdram_data;

    logic [7:0]                  hdr [32];
    logic [7:0]                  bank0_img [16];            // bank 0 bytes by offset
    logic [7:0]                  gfx_img [int unsigned];    // bank 1 bytes by offset
    logic [mem_pkg::SLOT_AW-1:0] targets [N_TARGETS];
    logic [mem_pkg::SLOT_DW-1:0] exp_data [2];
    int                          issued [2] = '{0, 0};
    int                          served [2] = '{0, 0};
    logic                        flat;                      // single bank expected
    int                          bank1_words = 0;
    int                          req_count = 0;             // sdram read requests started
    logic                        req_seen = 1'b0;

    mem_map_top dut_i (.*);
    sdram_model sdram_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((DL_BYTES * 200 + N_FETCHES * 100) * CLK_PERIOD);
        $display("timeout: the run did not finish in time");
        abort_run();
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string what, input logic [mem_pkg::SLOT_DW-1:0] got,
                              input logic [mem_pkg::SLOT_DW-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cfg(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string what, input logic [mem_pkg::SDRAM_DW-1:0] got,
                              input logic [mem_pkg::SDRAM_DW-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // byte offset in bank 1 of the 32-bit entry a slot address maps to
    function automatic int unsigned byte_offset(input logic [16:0] a, input logic [5:0] banks,
                                                input logic flat_map);
        logic [2:0] bsel;
        if (flat_map) begin
            bsel = {2'b00, a[16]};
        end else if (a[16]) begin
            bsel = banks[5:3];
        end else begin
            bsel = banks[2:0];
        end
        return {11'd0, bsel, a[15:0], 2'b00};
    endfunction

    function automatic logic [mem_pkg::SLOT_DW-1:0] expected_fetch(input logic [16:0] a,
                                                                   input logic [5:0] banks,
                                                                   input logic flat_map);
        int unsigned off;
        off = byte_offset(a, banks, flat_map);
        return {gfx_img[off + 3], gfx_img[off + 2], gfx_img[off + 1], gfx_img[off]};
    endfunction

    task automatic send_byte(input logic [24:0] a, input logic [7:0] d);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        while (dwnld_busy) @(negedge clk);     // word still pending
    endtask

    task automatic load_entry(input int unsigned off);
        if (!gfx_img.exists(off)) begin
            for (int k = 0; k < 4; k++) begin
                gfx_img[off + k] = 8'($urandom);
                send_byte(GFX_BASE + 25'(off + k), gfx_img[off + k]);
            end
            bank1_words += 2;
        end
    endtask

    task automatic start_fetch(input int s, input logic [mem_pkg::SLOT_AW-1:0] a);
        exp_data[s] = expected_fetch(a, tile_bank, flat);
        issued[s]   = issued[s] + 1;
        if (s == 0) begin
            scr1_addr = a;
            scr1_cs   = 1'b1;
        end else begin
            scr2_addr = a;
            scr2_cs   = 1'b1;
        end
    endtask

    task automatic wait_served();
        while (served[0] != issued[0] || served[1] != issued[1]) @(negedge clk);
        scr1_cs = 1'b0;
        scr2_cs = 1'b0;
        @(negedge clk);
    endtask

    // rising edges of the read request
    always @(posedge clk) begin
        if (sdram_req && !req_seen) begin
            req_count++;
        end
        req_seen = sdram_req;
    end

    // compares each slot's data when its ok shows up
    always @(posedge clk) begin
        if (served[0] != issued[0] && scr1_ok) begin
            check_data("scroll 1 data", scr1_data, exp_data[0]);
            served[0] = served[0] + 1;
        end
        if (served[1] != issued[1] && scr2_ok) begin
            check_data("scroll 2 data", scr2_data, exp_data[1]);
            served[1] = served[1] + 1;
        end
    end

    initial begin
        int reads0;
        int reqs0;
        void'($urandom(32'haf26eca4));
        rst         = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        lvbl        = 1'b1;
        vrender     = '0;
        // both halves distinct from each other and from the flat banks
        tile_bank   = {3'($urandom_range(7, 4)), 3'($urandom_range(3, 2))};
        scr1_addr   = '0;
        scr1_cs     = 1'b0;
        scr2_addr   = '0;
        scr2_cs     = 1'b0;
        flat        = 1'b0;
        foreach (hdr[i]) hdr[i] = 8'($urandom);
        hdr[mem_pkg::HDR_GAME_ADDR][4] = 1'b0;     // banked tiles first
        foreach (targets[i]) targets[i] = 17'($urandom);
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // header, some bank 0, then every entry the fetches need
        downloading = 1'b1;
        for (int i = 0; i < 32; i++) begin
            send_byte(25'(i), hdr[i]);
        end
        for (int i = 0; i < 16; i++) begin
            bank0_img[i] = 8'($urandom);
            send_byte(25'(mem_pkg::HEADER_LEN + i), bank0_img[i]);
        end
        foreach (targets[i]) begin
            load_entry(byte_offset(targets[i], tile_bank, 1'b0));
            load_entry(byte_offset(targets[i], tile_bank, 1'b1));
        end
        downloading = 1'b0;
        repeat (2) @(negedge clk);

        check_cfg("game id", game_id, hdr[mem_pkg::HDR_GAME_ADDR]);
        check_cfg("decoder enable", {7'd0, dec_en}, {7'd0, |hdr[mem_pkg::HDR_CFG_ADDR][1:0]});
        if (sdram_i.bank0_writes != 8 || sdram_i.bank1_writes != bank1_words) begin
            $display("error: %0d bank 0 and %0d bank 1 writes reached sdram, expected 8 and %0d",
                     sdram_i.bank0_writes, sdram_i.bank1_writes, bank1_words);
            abort_run();
        end
        for (int i = 0; i < 8; i++) begin
            check_word("bank 0 word", sdram_i.bank0[32'(i)],
                       {bank0_img[2 * i + 1], bank0_img[2 * i]});
        end
        foreach (gfx_img[k]) begin
            if (k[0] == 1'b0) begin
                check_word("bank 1 word", sdram_i.bank1[k >> 1], {gfx_img[k + 1], gfx_img[k]});
            end
        end

        foreach (targets[i]) begin
            start_fetch(i % 2, targets[i]);
            wait_served();
        end
        reqs0 = req_count;
        start_fetch(1, targets[N_TARGETS - 1]);    // still cached in slot 1
        wait_served();
        if (req_count != reqs0) begin
            $display("error: a repeated address went back to sdram at %0t ns", $time);
            abort_run();
        end
        start_fetch(0, targets[N_TARGETS - 1]);    // swapped, both slots miss
        start_fetch(1, targets[N_TARGETS - 2]);
        wait_served();

        // game id with bit 4 set selects the flat tile bank
        downloading = 1'b1;
        send_byte(25'(mem_pkg::HDR_GAME_ADDR), hdr[mem_pkg::HDR_GAME_ADDR] | 8'h10);
        downloading = 1'b0;
        repeat (2) @(negedge clk);
        check_cfg("game id", game_id, hdr[mem_pkg::HDR_GAME_ADDR] | 8'h10);
        flat = 1'b1;
        foreach (targets[i]) begin
            start_fetch((i + 1) % 2, targets[i]);
            wait_served();
        end

        lvbl      = 1'b0;
        vrender   = 9'($urandom_range(255, 1));
        reads0    = sdram_i.reads;
        scr2_addr = 17'($urandom);
        scr2_cs   = 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (sdram_req || scr2_ok || sdram_i.reads != reads0) begin
                $display("error: fetch served outside the graphics window at %0t ns", $time);
                abort_run();
            end
        end
        scr2_cs = 1'b0;
        lvbl    = 1'b1;
        @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== sdram_model.sv ====
// sdram model for the memory map
`timescale 1ns/1ns

module sdram_model (
    input  logic        clk,
    input  logic [21:0] prog_addr,
    input  logic [15:0] prog_data,
    input  logic [1:0]  prog_ba,
    input  logic        prog_we,
    output logic        prog_ack,
    input  logic [21:0] sdram_addr,
    input  logic        sdram_req,
    output logic        sdram_ack,
    output logic        sdram_dst,
    output logic        sdram_rdy,
    output logic [15:0] sdram_data
);
    logic [15:0] bank0 [int unsigned];
    logic [15:0] bank1 [int unsigned];
    int          bank0_writes = 0;
    int          bank1_writes = 0;
    int          reads = 0;         // read bursts served

    // programming port, one ack per word
    initial begin
        prog_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (prog_we) begin
                repeat ($urandom_range(2, 0)) @(posedge clk);
                if (prog_ba == 2'd1) begin
                    bank1[32'(prog_addr)] = prog_data;
                    bank1_writes++;
                end else begin
                    bank0[32'(prog_addr)] = prog_data;
                    bank0_writes++;
                end
                prog_ack <= 1'b1;
                @(posedge clk);
                prog_ack <= 1'b0;
            end
        end
    end

    // graphics bank reads, two word bursts
    initial begin
        int unsigned base;
        sdram_ack  = 1'b0;
        sdram_dst  = 1'b0;
        sdram_rdy  = 1'b0;
        sdram_data = '0;
        forever begin
            @(posedge clk);
            if (sdram_req) begin
                repeat ($urandom_range(5, 1)) @(posedge clk);
                base = 32'(sdram_addr);
                reads++;
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack  <= 1'b0;
                sdram_dst  <= 1'b1;
                sdram_data <= bank1[base];
                @(posedge clk);
                sdram_dst  <= 1'b0;
                sdram_rdy  <= 1'b1;
                sdram_data <= bank1[base + 1];
                @(posedge clk);
                sdram_rdy <= 1'b0;
            end
        end
    end

endmodule

// ==== mem_map_top.sv ====
// arcade memory map top
`timescale 1ns/1ns

module mem_map_top (
    input  logic                         clk,
    input  logic                         rst,
    // rom download
    input  logic                         downloading,
    input  logic [24:0]                  ioctl_addr,
    input  logic [7:0]                   ioctl_dout,
    input  logic                         ioctl_wr,
    output logic                         dwnld_busy,
    output logic [7:0]                   game_id,
    output logic                         dec_en,
    // sdram programming port
    output logic [mem_pkg::SDRAM_AW-1:0] prog_addr,
    output logic [mem_pkg::SDRAM_DW-1:0] prog_data,
    output logic [1:0]                   prog_ba,
    output logic                         prog_we,
    input  logic                         prog_ack,
    // video timing and tile banking
    input  logic                         lvbl,
    input  logic [8:0]                   vrender,
    input  logic [5:0]                   tile_bank,
    // scroll fetches
    input  logic [mem_pkg::SLOT_AW-1:0]  scr1_addr,
    input  logic                         scr1_cs,
    output logic                         scr1_ok,
    output logic [mem_pkg::SLOT_DW-1:0]  scr1_data,
    input  logic [mem_pkg::SLOT_AW-1:0]  scr2_addr,
    input  logic                         scr2_cs,
    output logic                         scr2_ok,
    output logic [mem_pkg::SLOT_DW-1:0]  scr2_data,
    // graphics read bank
    output logic [mem_pkg::SDRAM_AW-1:0] sdram_addr,
    output logic                         sdram_req,
    input  logic                         sdram_ack,
    input  logic                         sdram_dst,
    input  logic                         sdram_rdy,
    input  logic [mem_pkg::SDRAM_DW-1:0] sdram_data
);
    logic header;
    logic single_bank;

    gfx_slot_if #(.AW(mem_pkg::SLOT_AW)) scr1_if ();
    gfx_slot_if #(.AW(mem_pkg::SLOT_AW)) scr2_if ();
    gfx_slot_if #(.AW(mem_pkg::MAP_AW))  map1_if ();    // banked, toward the arbiter
    gfx_slot_if #(.AW(mem_pkg::MAP_AW))  map2_if ();

    assign scr1_if.addr = scr1_addr;
    assign scr1_if.cs   = scr1_cs;
    assign scr1_ok      = scr1_if.ok;
    assign scr1_data    = scr1_if.data;
    assign scr2_if.addr = scr2_addr;
    assign scr2_if.cs   = scr2_cs;
    assign scr2_ok      = scr2_if.ok;
    assign scr2_data    = scr2_if.data;

    rom_header_regs u_hdr (
        .clk         (clk),
        .rst         (rst),
        .header      (header),
        .ioctl_wr    (ioctl_wr),
        .ioctl_addr  (ioctl_addr[4:0]),
        .ioctl_dout  (ioctl_dout),
        .game_id     (game_id),
        .single_bank (single_bank),
        .dec_en      (dec_en)
    );

    rom_loader u_loader (
        .clk         (clk),
        .rst         (rst),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .header      (header),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_ba     (prog_ba),
        .prog_we     (prog_we),
        .prog_ack    (prog_ack),
        .dwnld_busy  (dwnld_busy)
    );

    gfx_bank_map u_map (
        .lvbl        (lvbl),
        .vrender     (vrender),
        .tile_bank   (tile_bank),
        .single_bank (single_bank),
        .scr1        (scr1_if.server),
        .scr2        (scr2_if.server),
        .map1        (map1_if.client),
        .map2        (map2_if.client)
    );

    rom_slot_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .slot0       (map1_if.server),
        .slot1       (map2_if.server),
        .sdram_addr  (sdram_addr),
        .sdram_req   (sdram_req),
        .sdram_ack   (sdram_ack),
        .sdram_dst   (sdram_dst),
        .sdram_rdy   (sdram_rdy),
        .sdram_data  (sdram_data)
    );

endmodule

// ==== rom_slot_arbiter.sv ====
// two slot cached rom read arbiter
`timescale 1ns/1ns

module rom_slot_arbiter (
    input  logic                         clk,
    input  logic                         rst,
    gfx_slot_if.server                   slot0,
    gfx_slot_if.server                   slot1,
    output logic [mem_pkg::SDRAM_AW-1:0] sdram_addr,
    output logic                         sdram_req,
    input  logic                         sdram_ack,
    input  logic                         sdram_dst,
    input  logic                         sdram_rdy,
    input  logic [mem_pkg::SDRAM_DW-1:0] sdram_data
);
    mem_pkg::arb_state_e state;

    logic [mem_pkg::MAP_AW-1:0]   slot_addr  [2];
    logic [1:0]                   slot_cs;
    logic [mem_pkg::MAP_AW-1:0]   cache_addr [2];
    logic [mem_pkg::SLOT_DW-1:0]  cache_data [2];
    logic [1:0]                   cache_vld;
    logic [1:0]                   hit;
    logic [1:0]                   miss;
    logic [1:0]                   fill;       // burst for this slot ends now
    logic [1:0]                   ok_r;
    logic [mem_pkg::MAP_AW-1:0]   req_addr;
    logic [mem_pkg::SDRAM_DW-1:0] first_word;
    logic                         sel;        // slot owning the burst
    logic                         rr;         // preferred slot on a double miss
    logic                         grant;
    logic                         burst_end;

    assign slot_addr[0] = slot0.addr;
    assign slot_addr[1] = slot1.addr;
    assign slot_cs      = {slot1.cs, slot0.cs};

    assign burst_end = (state == mem_pkg::wait_data) && sdram_rdy;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hit[i]  = cache_vld[i] && (cache_addr[i] == slot_addr[i]);
            miss[i] = slot_cs[i] && !hit[i];
            fill[i] = burst_end && (sel == 1'(i)) && (req_addr == slot_addr[i]);
        end
    end

    assign grant = (miss == 2'b11) ? rr : miss[1];

    // two words per entry, one burst in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= mem_pkg::idle;
            sdram_req <= 1'b0;
            sel       <= 1'b0;
            rr        <= 1'b0;
            cache_vld <= '0;
        end else begin
            case (state)
                mem_pkg::idle: begin
                    if (|miss) begin
                        sel       <= grant;
                        sdram_req <= 1'b1;
                        state     <= mem_pkg::wait_ack;
                    end
                end
                mem_pkg::wait_ack: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= mem_pkg::wait_data;
                    end
                end
                mem_pkg::wait_data: begin
                    if (sdram_rdy) begin
                        cache_vld[sel] <= 1'b1;
                        rr             <= ~sel;     // other slot goes first next time
                        state          <= mem_pkg::idle;
                    end
                end
                default: state <= mem_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mem_pkg::idle && |miss) begin
            req_addr <= slot_addr[grant];
        end
        if (sdram_dst) begin
            first_word <= sdram_data;   // low half
        end
        if (burst_end) begin
            cache_addr[sel] <= req_addr;
            cache_data[sel] <= {sdram_data, first_word};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ok_r <= '0;
        end else begin
            ok_r <= slot_cs & (hit | fill);
        end
    end

    // ok drops as soon as the slot moves off the cached address
    assign slot0.ok   = ok_r[0] && hit[0];
    assign slot1.ok   = ok_r[1] && hit[1];
    assign slot0.data = cache_data[0];
    assign slot1.data = cache_data[1];

    // word address is the mapped 32-bit address doubled
    assign sdram_addr = {{(mem_pkg::SDRAM_AW - mem_pkg::MAP_AW - 1){1'b0}}, req_addr, 1'b0};

endmodule

// ==== gfx_bank_map.sv ====
// scroll tile bank mapping
`timescale 1ns/1ns

module gfx_bank_map (
    input  logic       lvbl,
    input  logic [8:0] vrender,
    input  logic [5:0] tile_bank,
    input  logic       single_bank,
    gfx_slot_if.server scr1,
    gfx_slot_if.server scr2,
    gfx_slot_if.client map1,
    gfx_slot_if.client map2
);
    logic gfx_win;

    // bank bits placed above the 16-bit tile offset
    function automatic logic [2:0] bank_sel(
        input logic       hi,
        input logic       flat,
        input logic [5:0] banks
    );
        logic [2:0] sel;
        if (flat) begin
            sel = {2'b00, hi};
        end else if (hi) begin
            sel = banks[5:3];
        end else begin
            sel = banks[2:0];
        end
        return sel;
    endfunction

    // fetches allowed in blanking and on the first and last lines
    assign gfx_win = lvbl || (vrender == 9'd0) || vrender[8];

    assign map1.addr = {bank_sel(scr1.addr[16], single_bank, tile_bank), scr1.addr[15:0]};
    assign map1.cs   = scr1.cs && gfx_win;
    assign scr1.ok   = map1.ok;
    assign scr1.data = map1.data;

    assign map2.addr = {bank_sel(scr2.addr[16], single_bank, tile_bank), scr2.addr[15:0]};
    assign map2.cs   = scr2.cs && gfx_win;
    assign scr2.ok   = map2.ok;
    assign scr2.data = map2.data;

endmodule

// ==== rom_loader.sv ====
// rom download to sdram word writer
`timescale 1ns/1ns

module rom_loader (
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,
    output logic        header,
    output logic [21:0] prog_addr,
    output logic [15:0] prog_data,
    output logic [1:0]  prog_ba,
    output logic        prog_we,
    input  logic        prog_ack,
    output logic        dwnld_busy
);
    logic [24:0] offset;    // byte offset past the header
    logic [24:0] bank_off;  // byte offset inside the chosen bank
    logic        in_gfx;
    logic        body_wr;
    logic        word_done;
    logic [7:0]  low_byte;

    assign header = downloading && (ioctl_addr < 25'(mem_pkg::HEADER_LEN));

    assign offset    = ioctl_addr - 25'(mem_pkg::HEADER_LEN);
    assign in_gfx    = offset >= mem_pkg::GFX_START;
    assign bank_off  = in_gfx ? offset - mem_pkg::GFX_START : offset;
    assign body_wr   = downloading && ioctl_wr && !header;
    assign word_done = body_wr && offset[0];    // upper byte closes the word

    // even byte waits here for its partner
    always_ff @(posedge clk) begin
        if (body_wr && !offset[0]) begin
            low_byte <= ioctl_dout;
        end
    end

    always_ff @(posedge clk) begin
        if (word_done) begin
            prog_data <= {ioctl_dout, low_byte};
            prog_addr <= bank_off[22:1];            // byte offset halved
            prog_ba   <= in_gfx ? 2'd1 : 2'd0;
        end
    end

    // write request lives until the sdram side takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
        end else if (word_done) begin
            prog_we <= 1'b1;
        end else if (prog_ack) begin
            prog_we <= 1'b0;
        end
    end

    // host holds off the next pair while a word is pending
    assign dwnld_busy = prog_we;

endmodule

// ==== rom_header_regs.sv ====
// rom header configuration registers
`timescale 1ns/1ns

module rom_header_regs (
    input  logic       clk,
    input  logic       rst,
    input  logic       header,
    input  logic       ioctl_wr,
    input  logic [4:0] ioctl_addr,
    input  logic [7:0] ioctl_dout,
    output logic [7:0] game_id,
    output logic       single_bank,
    output logic       dec_en
);
    logic [1:0] dec_flags;  // decoder type bits of the cfg byte
    logic       hdr_wr;

    assign hdr_wr = header && ioctl_wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_flags <= '0;
            game_id   <= '0;
        end else if (hdr_wr) begin
            if (ioctl_addr == mem_pkg::HDR_CFG_ADDR) begin
                dec_flags <= ioctl_dout[1:0];
            end
            if (ioctl_addr == mem_pkg::HDR_GAME_ADDR) begin
                game_id <= ioctl_dout;
            end
        end
    end

    // games with id bit 4 set use one flat tile bank
    always_ff @(posedge clk) begin
        if (rst) begin
            single_bank <= 1'b0;
        end else begin
            single_bank <= game_id[4];
        end
    end

    assign dec_en = |dec_flags;     // any decoder present

endmodule

// ==== gfx_slot_if.sv ====
// graphics fetch slot
`timescale 1ns/1ns

interface gfx_slot_if #(
    parameter int AW = mem_pkg::SLOT_AW
);
    logic [AW-1:0]               addr;
    logic                        cs;    // level, held by the client
    logic                        ok;
    logic [mem_pkg::SLOT_DW-1:0] data;

    modport client (
        output addr,
        output cs,
        input  ok,
        input  data
    );

    modport server (
        input  addr,
        input  cs,
        output ok,
        output data
    );

endinterface

// ==== mem_pkg.sv ====
// memory map shared definitions
package mem_pkg;

    // download image layout
    localparam int unsigned HEADER_LEN    = 32;          // header bytes, kept out of sdram
    localparam logic [4:0]  HDR_CFG_ADDR  = 5'h10;       // configuration flags
    localparam logic [4:0]  HDR_GAME_ADDR = 5'h18;       // game id

    // first byte of the graphics bank, counted after the header
    localparam logic [24:0] GFX_START = 25'h00_0400;

    // sdram word port
    localparam int SDRAM_AW = 22;
    localparam int SDRAM_DW = 16;

    // scroll fetch slots
    localparam int SLOT_AW = 17;
    localparam int SLOT_DW = 32;
    localparam int MAP_AW  = 19;    // three bank bits over a 16-bit offset

    // graphics read bank arbiter
    typedef enum logic [1:0] {
        idle,
        wait_ack,
        wait_data
    } arb_state_e;

endpackage
